/* rs_alu_settings.svh */
`ifndef RS_ALU_SETTINGS_SVH
`define RS_ALU_SETTINGS_SVH

// station geometry
`define RS_ENT_NUM 8
`define RS_ENT_SEL 3

// datapath widths
`define DATA_LEN 32
`define ADDR_LEN 32

// rename tag, must fit inside DATA_LEN
`define RRF_SEL 6

`define ALU_OP_WIDTH 4

`endif

/* rs_alu_pkg.sv */
package rs_alu_pkg;

`include "rs_alu_settings.svh"

    typedef logic [`DATA_LEN-1:0]   data_t;
    typedef logic [`ADDR_LEN-1:0]   addr_t;
    typedef logic [`RRF_SEL-1:0]    rrf_tag_t;
    typedef logic [`RS_ENT_SEL-1:0] ent_sel_t;

    // one bit per entry
    typedef logic [`RS_ENT_NUM-1:0] ent_vec_t;

    // alu opcodes, encoded in list order
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

endpackage

/* rs_alu_dispatch_decode.sv */
`timescale 1ns/1ps

module rs_alu_dispatch_decode (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  we_1_i,
    input  logic                  we_2_i,
    input  rs_alu_pkg::ent_sel_t  write_addr_1_i,
    input  rs_alu_pkg::ent_sel_t  write_addr_2_i,
    input  logic                  clear_busy_i,
    input  rs_alu_pkg::ent_sel_t  issue_addr_i,
    output rs_alu_pkg::ent_vec_t  ent_we_o,
    output rs_alu_pkg::ent_vec_t  ent_from_2_o,
    output rs_alu_pkg::ent_vec_t  busy_o
);
    import rs_alu_pkg::*;

    ent_vec_t strobe_1;
    ent_vec_t strobe_2;
    ent_vec_t clear_vec;

    // one-hot write strobes per port
    always_comb begin
        strobe_1 = '0;
        strobe_2 = '0;
        if (we_1_i) begin
            strobe_1[write_addr_1_i] = 1'b1;
        end
        if (we_2_i) begin
            strobe_2[write_addr_2_i] = 1'b1;
        end
    end

    always_comb begin
        clear_vec = '0;
        if (clear_busy_i) begin
            clear_vec[issue_addr_i] = 1'b1;
        end
    end

    assign ent_we_o     = strobe_1 | strobe_2;
    // allocator never gives both ports the same entry
    assign ent_from_2_o = strobe_2;

    // clear has priority over a write to the same entry
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_o <= '0;
        end else begin
            busy_o <= (busy_o | ent_we_o) & ~clear_vec;
        end
    end

endmodule

/* rs_alu_entry.sv */
`timescale 1ns/1ps

`include "rs_alu_settings.svh"

module rs_alu_entry (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 we_i,
    input  rs_alu_pkg::addr_t    write_pc_i,
    input  rs_alu_pkg::data_t    write_op_1_i,
    input  rs_alu_pkg::data_t    write_op_2_i,
    input  logic                 write_valid_1_i,
    input  logic                 write_valid_2_i,
    input  rs_alu_pkg::data_t    write_imm_i,
    input  rs_alu_pkg::rrf_tag_t write_tag_i,
    input  logic                 write_dst_i,
    input  rs_alu_pkg::alu_op_e  write_alu_op_i,
    input  logic                 fwd_valid_1_i,
    input  rs_alu_pkg::rrf_tag_t fwd_tag_1_i,
    input  rs_alu_pkg::data_t    fwd_data_1_i,
    input  logic                 fwd_valid_2_i,
    input  rs_alu_pkg::rrf_tag_t fwd_tag_2_i,
    input  rs_alu_pkg::data_t    fwd_data_2_i,
    output rs_alu_pkg::data_t    op_1_o,
    output rs_alu_pkg::data_t    op_2_o,
    output logic                 ready_o,
    output rs_alu_pkg::addr_t    pc_o,
    output rs_alu_pkg::data_t    imm_o,
    output rs_alu_pkg::rrf_tag_t tag_o,
    output logic                 dst_o,
    output rs_alu_pkg::alu_op_e  alu_op_o
);
    import rs_alu_pkg::*;

    logic  valid_1_q;
    logic  valid_2_q;
    data_t base_op_1;
    data_t base_op_2;
    logic  base_valid_1;
    logic  base_valid_2;
    data_t next_op_1;
    data_t next_op_2;
    logic  next_valid_1;
    logic  next_valid_2;

    // pending operand holds its tag in the low bits
    function automatic logic wake_hit(
        input logic     valid,
        input data_t    op,
        input logic     fwd_valid,
        input rrf_tag_t fwd_tag
    );
        return !valid && fwd_valid && (op[`RRF_SEL-1:0] == fwd_tag);
    endfunction

    // a fresh write is woken the same way as a waiting entry
    always_comb begin
        base_op_1    = we_i ? write_op_1_i : op_1_o;
        base_op_2    = we_i ? write_op_2_i : op_2_o;
        base_valid_1 = we_i ? write_valid_1_i : valid_1_q;
        base_valid_2 = we_i ? write_valid_2_i : valid_2_q;

        next_op_1    = base_op_1;
        next_valid_1 = base_valid_1;
        if (wake_hit(base_valid_1, base_op_1, fwd_valid_1_i, fwd_tag_1_i)) begin
            next_op_1    = fwd_data_1_i;
            next_valid_1 = 1'b1;
        end else if (wake_hit(base_valid_1, base_op_1, fwd_valid_2_i, fwd_tag_2_i)) begin
            next_op_1    = fwd_data_2_i;
            next_valid_1 = 1'b1;
        end

        next_op_2    = base_op_2;
        next_valid_2 = base_valid_2;
        if (wake_hit(base_valid_2, base_op_2, fwd_valid_1_i, fwd_tag_1_i)) begin
            next_op_2    = fwd_data_1_i;
            next_valid_2 = 1'b1;
        end else if (wake_hit(base_valid_2, base_op_2, fwd_valid_2_i, fwd_tag_2_i)) begin
            next_op_2    = fwd_data_2_i;
            next_valid_2 = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_1_q <= 1'b0;
            valid_2_q <= 1'b0;
        end else begin
            valid_1_q <= next_valid_1;
            valid_2_q <= next_valid_2;
        end
    end

    always_ff @(posedge clk_i) begin
        op_1_o <= next_op_1;
        op_2_o <= next_op_2;
        if (we_i) begin
            pc_o     <= write_pc_i;
            imm_o    <= write_imm_i;
            tag_o    <= write_tag_i;
            dst_o    <= write_dst_i;
            alu_op_o <= write_alu_op_i;
        end
    end

    assign ready_o = valid_1_q & valid_2_q;

endmodule

/* rs_alu_issue_select.sv */
`timescale 1ns/1ps

`include "rs_alu_settings.svh"

module rs_alu_issue_select (
    input  rs_alu_pkg::ent_sel_t issue_addr_i,
    input  rs_alu_pkg::ent_vec_t busy_i,
    input  rs_alu_pkg::ent_vec_t raw_ready_i,
    input  rs_alu_pkg::data_t    op_1_i [`RS_ENT_NUM],
    input  rs_alu_pkg::data_t    op_2_i [`RS_ENT_NUM],
    input  rs_alu_pkg::addr_t    pc_i [`RS_ENT_NUM],
    input  rs_alu_pkg::data_t    imm_i [`RS_ENT_NUM],
    input  rs_alu_pkg::rrf_tag_t tag_i [`RS_ENT_NUM],
    input  rs_alu_pkg::ent_vec_t dst_i,
    input  rs_alu_pkg::alu_op_e  alu_op_i [`RS_ENT_NUM],
    output rs_alu_pkg::ent_vec_t ready_o,
    output rs_alu_pkg::data_t    exe_op_1_o,
    output rs_alu_pkg::data_t    exe_op_2_o,
    output rs_alu_pkg::addr_t    exe_pc_o,
    output rs_alu_pkg::data_t    exe_imm_o,
    output rs_alu_pkg::rrf_tag_t exe_rrf_tag_o,
    output logic                 exe_dst_val_o,
    output rs_alu_pkg::alu_op_e  exe_alu_op_o
);

    // a freed entry keeps stale valid flags, so gate with busy
    assign ready_o = raw_ready_i & busy_i;

    // readout follows the issue address with no register
    assign exe_op_1_o    = op_1_i[issue_addr_i];
    assign exe_op_2_o    = op_2_i[issue_addr_i];
    assign exe_pc_o      = pc_i[issue_addr_i];
    assign exe_imm_o     = imm_i[issue_addr_i];
    assign exe_rrf_tag_o = tag_i[issue_addr_i];
    assign exe_dst_val_o = dst_i[issue_addr_i];
    assign exe_alu_op_o  = alu_op_i[issue_addr_i];

endmodule

/* rs_alu.sv */
`timescale 1ns/1ps

`include "rs_alu_settings.svh"

module rs_alu (
    input  logic                 clk_i,
    input  logic                 reset_i,
    // dispatch port 1
    input  logic                 we_1_i,
    input  rs_alu_pkg::ent_sel_t write_addr_1_i,
    input  rs_alu_pkg::addr_t    write_pc_1_i,
    input  rs_alu_pkg::data_t    write_op_1_1_i,
    input  rs_alu_pkg::data_t    write_op_1_2_i,
    input  logic                 write_valid_1_1_i,
    input  logic                 write_valid_1_2_i,
    input  rs_alu_pkg::data_t    write_imm_1_i,
    input  rs_alu_pkg::rrf_tag_t write_tag_1_i,
    input  logic                 write_dst_1_i,
    input  rs_alu_pkg::alu_op_e  write_alu_op_1_i,
    // dispatch port 2
    input  logic                 we_2_i,
    input  rs_alu_pkg::ent_sel_t write_addr_2_i,
    input  rs_alu_pkg::addr_t    write_pc_2_i,
    input  rs_alu_pkg::data_t    write_op_2_1_i,
    input  rs_alu_pkg::data_t    write_op_2_2_i,
    input  logic                 write_valid_2_1_i,
    input  logic                 write_valid_2_2_i,
    input  rs_alu_pkg::data_t    write_imm_2_i,
    input  rs_alu_pkg::rrf_tag_t write_tag_2_i,
    input  logic                 write_dst_2_i,
    input  rs_alu_pkg::alu_op_e  write_alu_op_2_i,
    // result broadcast buses
    input  logic                 fwd_valid_1_i,
    input  rs_alu_pkg::rrf_tag_t fwd_tag_1_i,
    input  rs_alu_pkg::data_t    fwd_data_1_i,
    input  logic                 fwd_valid_2_i,
    input  rs_alu_pkg::rrf_tag_t fwd_tag_2_i,
    input  rs_alu_pkg::data_t    fwd_data_2_i,
    // issue side
    input  rs_alu_pkg::ent_sel_t issue_addr_i,
    input  logic                 clear_busy_i,
    output rs_alu_pkg::ent_vec_t busy_o,
    output rs_alu_pkg::ent_vec_t ready_o,
    output rs_alu_pkg::data_t    exe_op_1_o,
    output rs_alu_pkg::data_t    exe_op_2_o,
    output rs_alu_pkg::addr_t    exe_pc_o,
    output rs_alu_pkg::data_t    exe_imm_o,
    output rs_alu_pkg::rrf_tag_t exe_rrf_tag_o,
    output logic                 exe_dst_val_o,
    output rs_alu_pkg::alu_op_e  exe_alu_op_o
);
    import rs_alu_pkg::*;

    ent_vec_t ent_we;
    ent_vec_t ent_from_2;
    ent_vec_t raw_ready;
    ent_vec_t ent_dst;
    data_t    ent_op_1 [`RS_ENT_NUM];
    data_t    ent_op_2 [`RS_ENT_NUM];
    addr_t    ent_pc [`RS_ENT_NUM];
    data_t    ent_imm [`RS_ENT_NUM];
    rrf_tag_t ent_tag [`RS_ENT_NUM];
    alu_op_e  ent_alu_op [`RS_ENT_NUM];

    rs_alu_dispatch_decode u_decode (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .we_1_i         (we_1_i),
        .we_2_i         (we_2_i),
        .write_addr_1_i (write_addr_1_i),
        .write_addr_2_i (write_addr_2_i),
        .clear_busy_i   (clear_busy_i),
        .issue_addr_i   (issue_addr_i),
        .ent_we_o       (ent_we),
        .ent_from_2_o   (ent_from_2),
        .busy_o         (busy_o)
    );

    // fields default to port 1 and only matter when the strobe is set
    for (genvar i = 0; i < `RS_ENT_NUM; i++) begin : g_entry
        rs_alu_entry u_entry (
            .clk_i           (clk_i),
            .reset_i         (reset_i),
            .we_i            (ent_we[i]),
            .write_pc_i      (ent_from_2[i] ? write_pc_2_i : write_pc_1_i),
            .write_op_1_i    (ent_from_2[i] ? write_op_2_1_i : write_op_1_1_i),
            .write_op_2_i    (ent_from_2[i] ? write_op_2_2_i : write_op_1_2_i),
            .write_valid_1_i (ent_from_2[i] ? write_valid_2_1_i : write_valid_1_1_i),
            .write_valid_2_i (ent_from_2[i] ? write_valid_2_2_i : write_valid_1_2_i),
            .write_imm_i     (ent_from_2[i] ? write_imm_2_i : write_imm_1_i),
            .write_tag_i     (ent_from_2[i] ? write_tag_2_i : write_tag_1_i),
            .write_dst_i     (ent_from_2[i] ? write_dst_2_i : write_dst_1_i),
            .write_alu_op_i  (ent_from_2[i] ? write_alu_op_2_i : write_alu_op_1_i),
            .fwd_valid_1_i   (fwd_valid_1_i),
            .fwd_tag_1_i     (fwd_tag_1_i),
            .fwd_data_1_i    (fwd_data_1_i),
            .fwd_valid_2_i   (fwd_valid_2_i),
            .fwd_tag_2_i     (fwd_tag_2_i),
            .fwd_data_2_i    (fwd_data_2_i),
            .op_1_o          (ent_op_1[i]),
            .op_2_o          (ent_op_2[i]),
            .ready_o         (raw_ready[i]),
            .pc_o            (ent_pc[i]),
            .imm_o           (ent_imm[i]),
            .tag_o           (ent_tag[i]),
            .dst_o           (ent_dst[i]),
            .alu_op_o        (ent_alu_op[i])
        );
    end

    rs_alu_issue_select u_select (
        .issue_addr_i  (issue_addr_i),
        .busy_i        (busy_o),
        .raw_ready_i   (raw_ready),
        .op_1_i        (ent_op_1),
        .op_2_i        (ent_op_2),
        .pc_i          (ent_pc),
        .imm_i         (ent_imm),
        .tag_i         (ent_tag),
        .dst_i         (ent_dst),
        .alu_op_i      (ent_alu_op),
        .ready_o       (ready_o),
        .exe_op_1_o    (exe_op_1_o),
        .exe_op_2_o    (exe_op_2_o),
        .exe_pc_o      (exe_pc_o),
        .exe_imm_o     (exe_imm_o),
        .exe_rrf_tag_o (exe_rrf_tag_o),
        .exe_dst_val_o (exe_dst_val_o),
        .exe_alu_op_o  (exe_alu_op_o)
    );

endmodule

/* rs_alu_checker.sv */
`timescale 1ns/1ps

`include "rs_alu_settings.svh"

module rs_alu_checker (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 we_1_i,
    input rs_alu_pkg::ent_sel_t write_addr_1_i,
    input rs_alu_pkg::addr_t    write_pc_1_i,
    input rs_alu_pkg::data_t    write_op_1_1_i,
    input rs_alu_pkg::data_t    write_op_1_2_i,
    input logic                 write_valid_1_1_i,
    input logic                 write_valid_1_2_i,
    input rs_alu_pkg::data_t    write_imm_1_i,
    input rs_alu_pkg::rrf_tag_t write_tag_1_i,
    input logic                 write_dst_1_i,
    input rs_alu_pkg::alu_op_e  write_alu_op_1_i,
    input logic                 we_2_i,
    input rs_alu_pkg::ent_sel_t write_addr_2_i,
    input rs_alu_pkg::addr_t    write_pc_2_i,
    input rs_alu_pkg::data_t    write_op_2_1_i,
    input rs_alu_pkg::data_t    write_op_2_2_i,
    input logic                 write_valid_2_1_i,
    input logic                 write_valid_2_2_i,
    input rs_alu_pkg::data_t    write_imm_2_i,
    input rs_alu_pkg::rrf_tag_t write_tag_2_i,
    input logic                 write_dst_2_i,
    input rs_alu_pkg::alu_op_e  write_alu_op_2_i,
    input logic                 fwd_valid_1_i,
    input rs_alu_pkg::rrf_tag_t fwd_tag_1_i,
    input rs_alu_pkg::data_t    fwd_data_1_i,
    input logic                 fwd_valid_2_i,
    input rs_alu_pkg::rrf_tag_t fwd_tag_2_i,
    input rs_alu_pkg::data_t    fwd_data_2_i,
    input rs_alu_pkg::ent_sel_t issue_addr_i,
    input logic                 clear_busy_i,
    input rs_alu_pkg::ent_vec_t busy_o,
    input rs_alu_pkg::ent_vec_t ready_o,
    input rs_alu_pkg::data_t    exe_op_1_o,
    input rs_alu_pkg::data_t    exe_op_2_o,
    input rs_alu_pkg::addr_t    exe_pc_o,
    input rs_alu_pkg::data_t    exe_imm_o,
    input rs_alu_pkg::rrf_tag_t exe_rrf_tag_o,
    input logic                 exe_dst_val_o,
    input rs_alu_pkg::alu_op_e  exe_alu_op_o
);
    import rs_alu_pkg::*;

    string    test_name = "none";
    int       test_count = 0;
    int       check_count = 0;
    int       fail_count = 0;
    int       fails_before = 0;
    ent_vec_t m_busy;
    logic     m_valid_1 [`RS_ENT_NUM];
    logic     m_valid_2 [`RS_ENT_NUM];
    data_t    m_op_1 [`RS_ENT_NUM];
    data_t    m_op_2 [`RS_ENT_NUM];
    addr_t    m_pc [`RS_ENT_NUM];
    data_t    m_imm [`RS_ENT_NUM];
    rrf_tag_t m_tag [`RS_ENT_NUM];
    logic     m_dst [`RS_ENT_NUM];
    alu_op_e  m_alu_op [`RS_ENT_NUM];

    // returns {valid, value} after looking at both buses, bus 1 first
    function automatic logic [`DATA_LEN:0] woken(input logic valid, input data_t op);
        if (valid) begin
            return {1'b1, op};
        end
        if (fwd_valid_1_i && op[`RRF_SEL-1:0] == fwd_tag_1_i) begin
            return {1'b1, fwd_data_1_i};
        end
        if (fwd_valid_2_i && op[`RRF_SEL-1:0] == fwd_tag_2_i) begin
            return {1'b1, fwd_data_2_i};
        end
        return {1'b0, op};
    endfunction

    always @(posedge clk_i) begin
        if (reset_i) begin
            m_busy = '0;
            for (int i = 0; i < `RS_ENT_NUM; i++) begin
                m_valid_1[i] = 1'b0;
                m_valid_2[i] = 1'b0;
            end
        end else begin
            for (int i = 0; i < `RS_ENT_NUM; i++) begin
                if (we_1_i && write_addr_1_i == i) begin
                    m_busy[i]    = 1'b1;
                    m_valid_1[i] = write_valid_1_1_i;
                    m_valid_2[i] = write_valid_1_2_i;
                    m_op_1[i]    = write_op_1_1_i;
                    m_op_2[i]    = write_op_1_2_i;
                    m_pc[i]      = write_pc_1_i;
                    m_imm[i]     = write_imm_1_i;
                    m_tag[i]     = write_tag_1_i;
                    m_dst[i]     = write_dst_1_i;
                    m_alu_op[i]  = write_alu_op_1_i;
                end else if (we_2_i && write_addr_2_i == i) begin
                    m_busy[i]    = 1'b1;
                    m_valid_1[i] = write_valid_2_1_i;
                    m_valid_2[i] = write_valid_2_2_i;
                    m_op_1[i]    = write_op_2_1_i;
                    m_op_2[i]    = write_op_2_2_i;
                    m_pc[i]      = write_pc_2_i;
                    m_imm[i]     = write_imm_2_i;
                    m_tag[i]     = write_tag_2_i;
                    m_dst[i]     = write_dst_2_i;
                    m_alu_op[i]  = write_alu_op_2_i;
                end
                {m_valid_1[i], m_op_1[i]} = woken(m_valid_1[i], m_op_1[i]);
                {m_valid_2[i], m_op_2[i]} = woken(m_valid_2[i], m_op_2[i]);
            end
            if (clear_busy_i) begin
                m_busy[issue_addr_i] = 1'b0;
            end
        end
    end

    task automatic compare(input string what, input logic [`DATA_LEN-1:0] exp,
                           input logic [`DATA_LEN-1:0] act);
        check_count++;
        if (exp !== act) begin
            fail_count++;
            $display("Fail %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // mid-cycle, inputs and outputs are settled
    always @(negedge clk_i) begin
        ent_vec_t exp_ready;
        if (!reset_i) begin
            for (int i = 0; i < `RS_ENT_NUM; i++) begin
                exp_ready[i] = m_busy[i] & m_valid_1[i] & m_valid_2[i];
            end
            compare("busy_o", m_busy, busy_o);
            compare("ready_o", exp_ready, ready_o);
            if (m_busy[issue_addr_i]) begin
                compare("exe_op_1_o", m_op_1[issue_addr_i], exe_op_1_o);
                compare("exe_op_2_o", m_op_2[issue_addr_i], exe_op_2_o);
                compare("exe_pc_o", m_pc[issue_addr_i], exe_pc_o);
                compare("exe_imm_o", m_imm[issue_addr_i], exe_imm_o);
                compare("exe_rrf_tag_o", m_tag[issue_addr_i], exe_rrf_tag_o);
                compare("exe_dst_val_o", m_dst[issue_addr_i], exe_dst_val_o);
                compare("exe_alu_op_o", m_alu_op[issue_addr_i], exe_alu_op_o);
            end
        end
    end

    task automatic start_test(input string name);
        test_name = name;
        fails_before = fail_count;
    endtask

    task automatic end_test();
        test_count++;
        if (fail_count == fails_before) begin
            $display("%s passed", test_name);
        end else begin
            $display("%s failed with %0d errors", test_name, fail_count - fails_before);
        end
    endtask

    task automatic note_failure(input string msg);
        fail_count++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic print_counts();
        $display("%0d tests, %0d checks, %0d failures", test_count, check_count, fail_count);
    endtask

endmodule

/* tb_rs_alu.sv */
`timescale 1ns/1ps

`include "rs_alu_settings.svh"

module tb_rs_alu;
    import rs_alu_pkg::*;

    localparam int RANDOM_CYCLES = 300;
    localparam int WAIT_LIMIT = 20;

    integer   seed = 86770;
    ent_vec_t in_use;

    logic     clk_i;
    logic     reset_i;
    logic     we_1_i;
    ent_sel_t write_addr_1_i;
    addr_t    write_pc_1_i;
    data_t    write_op_1_1_i;
    data_t    write_op_1_2_i;
    logic     write_valid_1_1_i;
    logic     write_valid_1_2_i;
    data_t    write_imm_1_i;
    rrf_tag_t write_tag_1_i;
    logic     write_dst_1_i;
    alu_op_e  write_alu_op_1_i;
    logic     we_2_i;
    ent_sel_t write_addr_2_i;
    addr_t    write_pc_2_i;
    data_t    write_op_2_1_i;
    data_t    write_op_2_2_i;
    logic     write_valid_2_1_i;
    logic     write_valid_2_2_i;
    data_t    write_imm_2_i;
    rrf_tag_t write_tag_2_i;
    logic     write_dst_2_i;
    alu_op_e  write_alu_op_2_i;
    logic     fwd_valid_1_i;
    rrf_tag_t fwd_tag_1_i;
    data_t    fwd_data_1_i;
    logic     fwd_valid_2_i;
    rrf_tag_t fwd_tag_2_i;
    data_t    fwd_data_2_i;
    ent_sel_t issue_addr_i;
    logic     clear_busy_i;
    ent_vec_t busy_o;
    ent_vec_t ready_o;
    data_t    exe_op_1_o;
    data_t    exe_op_2_o;
    addr_t    exe_pc_o;
    data_t    exe_imm_o;
    rrf_tag_t exe_rrf_tag_o;
    logic     exe_dst_val_o;
    alu_op_e  exe_alu_op_o;

    rs_alu dut0 (.*);

    rs_alu_checker chk0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // small in-flight tag set so broadcasts often hit waiting entries
    function automatic rrf_tag_t pick_tag();
        return rrf_tag_t'({$random(seed)} % 8);
    endfunction

    // random entry whose mask bit is set, -1 if none
    function automatic int pick_entry(input ent_vec_t mask);
        int start;
        start = {$random(seed)} % `RS_ENT_NUM;
        for (int k = 0; k < `RS_ENT_NUM; k++) begin
            if (mask[(start + k) % `RS_ENT_NUM]) begin
                return (start + k) % `RS_ENT_NUM;
            end
        end
        return -1;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // a pending operand carries its tag in the low bits
    task automatic fill_port(input int port, input logic we, input ent_sel_t addr,
                             input logic pend_1, input logic pend_2);
        data_t op_1;
        data_t op_2;
        op_1 = pend_1 ? data_t'(pick_tag()) : data_t'($random(seed));
        op_2 = pend_2 ? data_t'(pick_tag()) : data_t'($random(seed));
        if (port == 1) begin
            we_1_i            = we;
            write_addr_1_i    = addr;
            write_pc_1_i      = $random(seed);
            write_op_1_1_i    = op_1;
            write_op_1_2_i    = op_2;
            write_valid_1_1_i = !pend_1;
            write_valid_1_2_i = !pend_2;
            write_imm_1_i     = $random(seed);
            write_tag_1_i     = $random(seed);
            write_dst_1_i     = $random(seed);
            write_alu_op_1_i  = alu_op_e'({$random(seed)} % 10);
        end else begin
            we_2_i            = we;
            write_addr_2_i    = addr;
            write_pc_2_i      = $random(seed);
            write_op_2_1_i    = op_1;
            write_op_2_2_i    = op_2;
            write_valid_2_1_i = !pend_1;
            write_valid_2_2_i = !pend_2;
            write_imm_2_i     = $random(seed);
            write_tag_2_i     = $random(seed);
            write_dst_2_i     = $random(seed);
            write_alu_op_2_i  = alu_op_e'({$random(seed)} % 10);
        end
    endtask

    task automatic dispatch(input int port, input ent_sel_t addr,
                            input logic pend_1, input logic pend_2);
        fill_port(port, 1'b1, addr, pend_1, pend_2);
        in_use[addr] = 1'b1;
    endtask

    task automatic set_buses(input logic v1, input rrf_tag_t t1,
                             input logic v2, input rrf_tag_t t2);
        fwd_valid_1_i = v1;
        fwd_tag_1_i   = t1;
        fwd_data_1_i  = $random(seed);
        fwd_valid_2_i = v2;
        fwd_tag_2_i   = t2;
        fwd_data_2_i  = $random(seed);
    endtask

    task automatic stop_inputs();
        we_1_i       = 1'b0;
        we_2_i       = 1'b0;
        clear_busy_i = 1'b0;
        set_buses(1'b0, '0, 1'b0, '0);
    endtask

    task automatic wait_for(input ent_sel_t addr, input logic busy_want, input logic ready_want);
        int n;
        n = 0;
        while ((busy_o[addr] !== busy_want || ready_o[addr] !== ready_want) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (busy_o[addr] !== busy_want || ready_o[addr] !== ready_want) begin
            chk0.note_failure($sformatf("timeout waiting for entry %0d to reach busy %0b ready %0b",
                                        addr, busy_want, ready_want));
        end
    endtask

    initial begin
        rrf_tag_t tag;
        int       c;
        int       a;
        in_use = '0;
        fill_port(1, 1'b0, '0, 1'b0, 1'b0);
        fill_port(2, 1'b0, '0, 1'b0, 1'b0);
        issue_addr_i = '0;
        stop_inputs();
        reset_i = 1'b1;
        repeat (16) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        chk0.start_test("reset");
        repeat (2) next_cycle();
        chk0.end_test();

        chk0.start_test("single_dispatch");
        dispatch(1, 2, 1'b0, 1'b0);
        issue_addr_i = 2;
        next_cycle();
        stop_inputs();
        wait_for(2, 1'b1, 1'b1);
        next_cycle();
        chk0.end_test();

        chk0.start_test("dual_dispatch");
        dispatch(1, 5, 1'b0, 1'b0);
        dispatch(2, 6, 1'b0, 1'b0);
        issue_addr_i = 5;
        next_cycle();
        stop_inputs();
        wait_for(5, 1'b1, 1'b1);
        next_cycle();
        issue_addr_i = 6;
        wait_for(6, 1'b1, 1'b1);
        next_cycle();
        chk0.end_test();

        chk0.start_test("wakeup");
        dispatch(1, 0, 1'b1, 1'b0);
        tag = write_op_1_1_i[`RRF_SEL-1:0];
        issue_addr_i = 0;
        next_cycle();
        stop_inputs();
        next_cycle();
        set_buses(1'b0, '0, 1'b1, tag);
        next_cycle();
        stop_inputs();
        wait_for(0, 1'b1, 1'b1);
        // match on the dispatch cycle itself
        dispatch(2, 1, 1'b1, 1'b1);
        set_buses(1'b1, write_op_2_1_i[`RRF_SEL-1:0], 1'b1, write_op_2_2_i[`RRF_SEL-1:0]);
        issue_addr_i = 1;
        next_cycle();
        stop_inputs();
        wait_for(1, 1'b1, 1'b1);
        next_cycle();
        chk0.end_test();

        chk0.start_test("clear_busy");
        issue_addr_i = 2;
        clear_busy_i = 1'b1;
        in_use[2] = 1'b0;
        next_cycle();
        stop_inputs();
        wait_for(2, 1'b0, 1'b0);
        dispatch(1, 2, 1'b0, 1'b0);
        next_cycle();
        stop_inputs();
        wait_for(2, 1'b1, 1'b1);
        next_cycle();
        chk0.end_test();

        chk0.start_test("random_mix");
        for (int cyc = 0; cyc < RANDOM_CYCLES; cyc++) begin
            stop_inputs();
            issue_addr_i = $random(seed);
            c = -1;
            if (in_use != '0 && {$random(seed)} % 4 == 0) begin
                c = pick_entry(in_use);
                issue_addr_i = c;
                clear_busy_i = 1'b1;
            end
            // issued entry is still marked in use, so no port can pick it
            a = pick_entry(~in_use);
            if (a >= 0 && {$random(seed)} % 2 == 0) begin
                dispatch(1, a, $random(seed), $random(seed));
            end
            a = pick_entry(~in_use);
            if (a >= 0 && {$random(seed)} % 2 == 0) begin
                dispatch(2, a, $random(seed), $random(seed));
            end
            set_buses($random(seed), pick_tag(), $random(seed), pick_tag());
            if (c >= 0) begin
                in_use[c] = 1'b0;
            end
            next_cycle();
        end
        stop_inputs();
        next_cycle();
        chk0.end_test();

        chk0.print_counts();
        if (chk0.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* rs_alu.f */
+incdir+.
rs_alu_pkg.sv
rs_alu_dispatch_decode.sv
rs_alu_entry.sv
rs_alu_issue_select.sv
rs_alu.sv
rs_alu_checker.sv
tb_rs_alu.sv
